/* design/cp0.sv */
module cp0(
	input  logic                     clk,
	input  logic                     rst,
	input  cpu_pkg::RegAddr_t        raddr,
	input  logic [2:0]               rsel,
	input  cpu_pkg::CP0RegWriteReq_t wr,
	except_if.cp0                    exc,
	input  logic                     tlbr_req,
	input  cpu_pkg::TLBEntry_t       tlbr_res,
	input  logic                     tlbp_req,
	input  cpu_pkg::Word_t           tlbp_res,
	input  logic [3:0]               rand4,
	input  cpu_pkg::Word_t           rand32,
	output cpu_pkg::Word_t           rdata,
	output cpu_pkg::CP0Regs_t        regs,
	output logic [7:0]               asid,
	output logic                     user_mode
);
	import cpu_pkg::*;

	CP0Regs_t regs_next;
	Word_t    wmask;
	Word_t    wr_old;

	cp0_write_mask u_write_mask (
		.sel  (wr.sel),
		.addr (wr.waddr),
		.mask (wmask)
	);

	assign asid      = regs.entry_hi[7:0];
	assign user_mode = regs.status.um && !regs.status.exl && !regs.status.erl;

	always_comb
	begin
		if (rsel == 3'd0)
			rdata = regs[raddr * REG_WIDTH +: REG_WIDTH];
		else
			rdata = '0;
	end

	// ****************************************
	// Next state, later updates override earlier ones.
	always_comb
	begin
		regs_next             = regs;
		regs_next.count       = regs.count + 32'd1;
		regs_next.random      = {28'd0, rand4};
		regs_next.impl_lfsr32 = rand32;
		wr_old                = regs[wr.waddr * REG_WIDTH +: REG_WIDTH];

		// MTC0 from write-back.
		if (wr.we && wr.sel == 3'd0)
		begin
			regs_next[wr.waddr * REG_WIDTH +: REG_WIDTH] =
				(wr.wdata & wmask) | (wr_old & ~wmask);
		end
		else if (wr.we && wr.sel == 3'd1 && wr.waddr == REG_PRID)
		begin
			regs_next.ebase[29:12] = wr.wdata[29:12];
		end

		if (tlbr_req)
		begin
			regs_next.entry_hi[31:13] = tlbr_res.vpn2;
			regs_next.entry_hi[7:0]   = tlbr_res.asid;
			regs_next.entry_lo0 = {2'b00, tlbr_res.pfn0, tlbr_res.c0,
				tlbr_res.d0, tlbr_res.v0, tlbr_res.G};
			regs_next.entry_lo1 = {2'b00, tlbr_res.pfn1, tlbr_res.c1,
				tlbr_res.d1, tlbr_res.v1, tlbr_res.G};
		end

		if (tlbp_req)
			regs_next.index = tlbp_res;

		// Exception entry and return.
		if (exc.flush && exc.eret)
		begin
			if (regs_next.status.erl)
				regs_next.status.erl = 1'b0;
			else
				regs_next.status.exl = 1'b0;
		end
		else if (exc.flush)
		begin
			if (!regs_next.status.exl)
			begin
				regs_next.epc      = exc.delayslot ? exc.cur_pc - 32'd4 : exc.cur_pc;
				regs_next.cause.bd = exc.delayslot;
			end
			regs_next.status.exl     = 1'b1;
			regs_next.cause.exc_code = exc.code;
			case (exc.code)
				EXC_INT:
					regs_next.cause.ip = exc.extra[7:0];
				EXC_ADEL, EXC_ADES:
					regs_next.bad_vaddr = exc.extra;
				EXC_TLBL, EXC_TLBS:
				begin
					regs_next.bad_vaddr       = exc.extra;
					regs_next.context_[22:4]  = exc.extra[31:13]; // BadVPN2.
					regs_next.entry_hi[31:13] = exc.extra[31:13];
				end
				default:
					;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regs        <= '0;
			regs.random <= TLB_ENTRIES_NUM - 1;
			regs.status <= STATUS_RESET;
			regs.ebase  <= EBASE_RESET;
		end
		else
		begin
			regs <= regs_next;
		end
	end

endmodule

/* design/cp0_random.sv */
module cp0_random(
	input  logic           clk,
	input  logic           rst,
	output logic [3:0]     val4,
	output cpu_pkg::Word_t val32
);
	import cpu_pkg::*;

	logic  fb4;
	logic  fb32;

	// x^4 + x^3 + 1.
	assign fb4 = val4[3] ^ val4[2];

	// x^32 + x^22 + x^2 + x + 1.
	assign fb32 = val32[31] ^ val32[21] ^ val32[1] ^ val32[0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			val4  <= 4'b1000;
			val32 <= 32'h0000_0001;
		end
		else
		begin
			val4  <= {val4[2:0], fb4};
			val32 <= {val32[30:0], fb32};
		end
	end

endmodule

/* design/cp0_top.sv */
module cp0_top(
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::RegAddr_t  raddr,
	input  logic [2:0]         rsel,
	input  logic               wr_we,
	input  logic [2:0]         wr_sel,
	input  cpu_pkg::RegAddr_t  wr_addr,
	input  cpu_pkg::Word_t     wr_data,
	input  logic [5:0]         ext_int,
	input  cpu_pkg::Word_t     pc,
	input  logic               in_delayslot,
	input  cpu_pkg::Word_t     bad_addr,
	input  logic               adel,
	input  logic               ades,
	input  logic               tlbl,
	input  logic               tlbs,
	input  logic               syscall,
	input  logic               brk,
	input  logic               eret,
	input  logic               tlbr_req,
	input  cpu_pkg::TLBEntry_t tlbr_res,
	input  logic               tlbp_req,
	input  cpu_pkg::Word_t     tlbp_res,
	output cpu_pkg::Word_t     rdata,
	output logic               flush,
	output cpu_pkg::Word_t     exc_target,
	output logic [7:0]         asid,
	output logic               user_mode
);
	import cpu_pkg::*;

	CP0RegWriteReq_t wr;
	CP0Regs_t        regs;
	logic [3:0]      rand4;
	Word_t           rand32;

	except_if exc ();

	assign wr    = '{we: wr_we, sel: wr_sel, waddr: wr_addr, wdata: wr_data};
	assign flush = exc.flush;

	except_gen u_except_gen (
		.ext_int      (ext_int),
		.pc           (pc),
		.in_delayslot (in_delayslot),
		.bad_addr     (bad_addr),
		.adel         (adel),
		.ades         (ades),
		.tlbl         (tlbl),
		.tlbs         (tlbs),
		.syscall      (syscall),
		.brk          (brk),
		.eret         (eret),
		.regs         (regs),
		.exc_target   (exc_target),
		.exc          (exc.gen)
	);

	cp0 u_cp0 (
		.clk       (clk),
		.rst       (rst),
		.raddr     (raddr),
		.rsel      (rsel),
		.wr        (wr),
		.exc       (exc.cp0),
		.tlbr_req  (tlbr_req),
		.tlbr_res  (tlbr_res),
		.tlbp_req  (tlbp_req),
		.tlbp_res  (tlbp_res),
		.rand4     (rand4),
		.rand32    (rand32),
		.rdata     (rdata),
		.regs      (regs),
		.asid      (asid),
		.user_mode (user_mode)
	);

	cp0_random u_random (
		.clk   (clk),
		.rst   (rst),
		.val4  (rand4),
		.val32 (rand32)
	);

endmodule

/* design/cp0_write_mask.sv */
module cp0_write_mask(
	input  logic [2:0]        sel,
	input  cpu_pkg::RegAddr_t addr,
	output cpu_pkg::Word_t    mask
);
	import cpu_pkg::*;

	always_comb
	begin
		mask = '0;
		if (sel == 3'd0)
		begin
			case (addr)
				REG_INDEX, REG_ENTRY_LO0, REG_ENTRY_LO1,
				REG_COMPARE, REG_EPC, REG_ERROR_EPC:
					mask = '1;
				REG_STATUS:
					mask = 32'h0040_FF17; // BEV, IM, UM, ERL, EXL, IE.
				REG_CAUSE:
					mask = 32'h0000_0300; // Software interrupts.
				REG_ENTRY_HI:
					mask = 32'hFFFF_E0FF; // VPN2 and ASID.
				REG_CONTEXT:
					mask = 32'hFF80_0000; // PTEBase.
				REG_WIRED:
					mask = 32'h0000_000F;
				default:
					mask = '0;
			endcase
		end
	end

endmodule

/* design/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [31:0] Word_t;
	typedef logic [4:0]  RegAddr_t;

	localparam int    REG_WIDTH       = 32;
	localparam int    TLB_ENTRIES_NUM = 16;
	localparam Word_t STATUS_RESET    = 32'h1040_0000; // CU0 and BEV.
	localparam Word_t EBASE_RESET     = 32'h8000_0001;
	localparam Word_t EXC_OFFSET      = 32'h0000_0180; // General exception.
	localparam Word_t BEV_BASE        = 32'hBFC0_0200;

	localparam RegAddr_t REG_INDEX     = 5'd0;
	localparam RegAddr_t REG_ENTRY_LO0 = 5'd2;
	localparam RegAddr_t REG_ENTRY_LO1 = 5'd3;
	localparam RegAddr_t REG_CONTEXT   = 5'd4;
	localparam RegAddr_t REG_WIRED     = 5'd6;
	localparam RegAddr_t REG_ENTRY_HI  = 5'd10;
	localparam RegAddr_t REG_COMPARE   = 5'd11;
	localparam RegAddr_t REG_STATUS    = 5'd12;
	localparam RegAddr_t REG_CAUSE     = 5'd13;
	localparam RegAddr_t REG_EPC       = 5'd14;
	localparam RegAddr_t REG_PRID      = 5'd15; // Select 1 is ebase.
	localparam RegAddr_t REG_ERROR_EPC = 5'd30;

	typedef enum logic [4:0] {
		EXC_INT  = 5'h00,
		EXC_TLBL = 5'h02,
		EXC_TLBS = 5'h03,
		EXC_ADEL = 5'h04,
		EXC_ADES = 5'h05,
		EXC_SYS  = 5'h08,
		EXC_BP   = 5'h09,
		EXC_RI   = 5'h0a
	} exc_code_t;

	typedef struct packed {
		logic [3:0] cu;
		logic [4:0] rsvd_27_23;
		logic       bev;
		logic [5:0] rsvd_21_16;
		logic [7:0] im;
		logic [2:0] rsvd_7_5;
		logic       um;
		logic       rsvd_3;
		logic       erl;
		logic       exl;
		logic       ie;
	} status_t;

	typedef struct packed {
		logic        bd;
		logic        rsvd_30;
		logic [1:0]  ce;
		logic [11:0] rsvd_27_16;
		logic [7:0]  ip;
		logic        rsvd_7;
		exc_code_t   exc_code;
		logic [1:0]  rsvd_1_0;
	} cause_t;

	// ****************************************
	// Register file image, register 0 in the low word.
	// Slot 31 holds ebase (register 15, select 1).
	typedef struct packed {
		Word_t              impl_lfsr32;
		Word_t              ebase;
		Word_t              error_epc;
		logic [12:0][31:0]  rsvd_29_17;
		Word_t              config0;
		Word_t              prid;
		Word_t              epc;
		cause_t             cause;
		status_t            status;
		Word_t              compare;
		Word_t              entry_hi;
		Word_t              count;
		Word_t              bad_vaddr;
		Word_t              rsvd_7;
		Word_t              wired;
		Word_t              page_mask;
		Word_t              context_;
		Word_t              entry_lo1;
		Word_t              entry_lo0;
		Word_t              random;
		Word_t              index;
	} CP0Regs_t;

	typedef struct packed {
		logic       we;
		logic [2:0] sel;
		RegAddr_t   waddr;
		Word_t      wdata;
	} CP0RegWriteReq_t;

	typedef struct packed {
		logic [18:0] vpn2;
		logic [7:0]  asid;
		logic        G;
		logic [23:0] pfn0;
		logic [23:0] pfn1;
		logic [2:0]  c0;
		logic [2:0]  c1;
		logic        d0;
		logic        d1;
		logic        v0;
		logic        v1;
	} TLBEntry_t;

endpackage

/* design/except_gen.sv */
module except_gen(
	input  logic [5:0]        ext_int,
	input  cpu_pkg::Word_t    pc,
	input  logic              in_delayslot,
	input  cpu_pkg::Word_t    bad_addr,
	input  logic              adel,
	input  logic              ades,
	input  logic              tlbl,
	input  logic              tlbs,
	input  logic              syscall,
	input  logic              brk,
	input  logic              eret,
	input  cpu_pkg::CP0Regs_t regs,
	output cpu_pkg::Word_t    exc_target,
	except_if.gen             exc
);
	import cpu_pkg::*;

	logic [7:0] pending;
	logic       int_taken;
	logic       eret_taken;
	Word_t      exc_base;

	assign pending   = {ext_int, regs.cause.ip[1:0]} & regs.status.im;
	assign int_taken = (|pending) && regs.status.ie
		&& !regs.status.exl && !regs.status.erl;

	assign exc.delayslot = in_delayslot;
	assign exc.cur_pc    = pc;
	assign exc.eret      = eret_taken;

	// ****************************************
	// Priority encoder, interrupt first.
	always_comb
	begin
		exc.flush  = 1'b1;
		exc.code   = EXC_INT;
		exc.extra  = '0;
		eret_taken = 1'b0;
		if (int_taken)
			exc.extra = {24'd0, pending};
		else if (adel)
		begin
			exc.code  = EXC_ADEL;
			exc.extra = bad_addr;
		end
		else if (ades)
		begin
			exc.code  = EXC_ADES;
			exc.extra = bad_addr;
		end
		else if (tlbl)
		begin
			exc.code  = EXC_TLBL;
			exc.extra = bad_addr;
		end
		else if (tlbs)
		begin
			exc.code  = EXC_TLBS;
			exc.extra = bad_addr;
		end
		else if (syscall)
			exc.code = EXC_SYS;
		else if (brk)
			exc.code = EXC_BP;
		else if (eret)
			eret_taken = 1'b1;
		else
			exc.flush = 1'b0;
	end

	assign exc_base = regs.status.bev ? BEV_BASE : {regs.ebase[31:12], 12'd0};

	always_comb
	begin
		if (eret_taken)
			exc_target = regs.status.erl ? regs.error_epc : regs.epc;
		else
			exc_target = exc_base + EXC_OFFSET;
	end

endmodule

/* design/except_if.sv */
interface except_if;
	import cpu_pkg::*;

	logic      flush;     // One-cycle strobe.
	logic      eret;
	logic      delayslot;
	Word_t     cur_pc;
	exc_code_t code;
	Word_t     extra;     // Pending set or faulting address.

	modport gen (
		output flush, eret, delayslot, cur_pc, code, extra
	);

	modport cp0 (
		input flush, eret, delayslot, cur_pc, code, extra
	);

endinterface

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cp0_tb -f sim.f -o sim_cp0
./obj_dir/sim_cp0 +verilator+error+limit+100 | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

/* sim.f */
design/cpu_pkg.sv
design/except_if.sv
design/cp0_write_mask.sv
design/cp0_random.sv
design/except_gen.sv
design/cp0.sv
design/cp0_top.sv
test/cp0_asserts.sv
test/cp0_tb.sv

/* test/cp0_asserts.sv */
module cp0_asserts(
	input logic              clk,
	input logic              rst,
	input logic              flush,
	input logic              eret,
	input cpu_pkg::CP0Regs_t regs
);
	int fail_count = 0; // Read by the testbench at the end.

	// ****************************************
	assert property (@(posedge clk) disable iff (rst) flush && !eret |=> regs.status.exl)
	else
	begin
		$error("EXL not set after exception entry");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (rst) regs.random != 32'd0)
	else
	begin
		$error("random register is zero");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (rst)
		1'b1 |=> regs.count == $past(regs.count) + 32'd1)
	else
	begin
		$error("count did not step by one");
		fail_count++;
	end

endmodule

bind cp0 cp0_asserts u_asserts (
	.clk   (clk),
	.rst   (rst),
	.flush (exc.flush),
	.eret  (exc.eret),
	.regs  (regs)
);

/* test/cp0_tb.sv */
module cp0_tb;
	import cpu_pkg::*;

	localparam int       NUM_TESTS     = 6;
	localparam int       CLK_PERIOD    = 10;
	localparam RegAddr_t REG_RANDOM    = 5'd1;
	localparam RegAddr_t REG_BAD_VADDR = 5'd8;
	localparam RegAddr_t REG_COUNT     = 5'd9;
	localparam Word_t    EBASE_VEC     = 32'h8000_0180;
	localparam Word_t    BEV_VEC       = 32'hBFC0_0380;

	logic       clk;
	logic       rst;
	RegAddr_t   raddr;
	logic [2:0] rsel;
	logic       wr_we;
	logic [2:0] wr_sel;
	RegAddr_t   wr_addr;
	Word_t      wr_data;
	logic [5:0] ext_int;
	Word_t      pc;
	logic       in_delayslot;
	Word_t      bad_addr;
	logic       adel, ades, tlbl, tlbs, syscall, brk, eret;
	logic       tlbr_req;
	TLBEntry_t  tlbr_res;
	logic       tlbp_req;
	Word_t      tlbp_res;
	Word_t      rdata;
	logic       flush;
	Word_t      exc_target;
	logic [7:0] asid;
	logic       user_mode;
	int         errors;
	int         assert_fails;

	cp0_top uut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ****************************************
	task automatic value_error(input string name, input Word_t got, input Word_t exp);
		errors++;
		$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
	endtask

	function automatic Word_t cause_word(input logic bd, input logic [7:0] ip,
		input logic [4:0] code);
		return {bd, 15'd0, ip, 1'b0, code, 2'b00};
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic clear_flags();
		ext_int      = '0;
		pc           = '0;
		in_delayslot = 1'b0;
		bad_addr     = '0;
		{adel, ades, tlbl, tlbs, syscall, brk, eret} = '0;
		tlbr_req     = 1'b0;
		tlbr_res     = '0;
		tlbp_req     = 1'b0;
		tlbp_res     = '0;
	endtask

	task automatic peek_reg(input RegAddr_t addr, output Word_t val);
		raddr = addr;
		rsel  = 3'd0;
		#1;
		val = rdata;
	endtask

	task automatic read_reg(input RegAddr_t addr, output Word_t val);
		step();
		peek_reg(addr, val);
	endtask

	task automatic expect_reg(input string name, input RegAddr_t addr, input Word_t exp);
		Word_t v;
		read_reg(addr, v);
		if (v !== exp)
			value_error(name, v, exp);
	endtask

	task automatic write_reg(input logic [2:0] sel, input RegAddr_t addr, input Word_t data);
		step();
		wr_we   = 1'b1;
		wr_sel  = sel;
		wr_addr = addr;
		wr_data = data;
		step();
		wr_we = 1'b0;
	endtask

	// Flags are already driven; check the same-cycle response, then drop them.
	task automatic pulse(input logic exp_flush, input Word_t exp_target);
		#1;
		if (flush !== exp_flush)
			value_error("flush", 32'(flush), 32'(exp_flush));
		if (exc_target !== exp_target)
			value_error("exc_target", exc_target, exp_target);
		step();
		clear_flags();
	endtask

	// ****************************************
	task automatic reset_values();
		Word_t v;
		peek_reg(REG_COUNT, v);
		if (v !== 32'd0)
			value_error("count after reset", v, 32'd0);
		peek_reg(REG_RANDOM, v);
		if (v !== 32'(TLB_ENTRIES_NUM - 1))
			value_error("random after reset", v, 32'(TLB_ENTRIES_NUM - 1));
		peek_reg(REG_INDEX, v);
		if (v !== 32'd0)
			value_error("index after reset", v, 32'd0);
		peek_reg(REG_STATUS, v);
		if (v !== STATUS_RESET)
			value_error("status after reset", v, STATUS_RESET);
		peek_reg(REG_CAUSE, v);
		if (v !== 32'd0)
			value_error("cause after reset", v, 32'd0);
		raddr = REG_STATUS;
		rsel  = 3'd1; // Select 1 reads as zero.
		#1;
		if (rdata !== 32'd0)
			value_error("select 1 read", rdata, 32'd0);
		if (user_mode !== 1'b0)
			value_error("user_mode after reset", 32'(user_mode), 32'd0);
		if (flush !== 1'b0)
			value_error("flush after reset", 32'(flush), 32'd0);
	endtask

	task automatic masked_writes();
		write_reg(3'd0, REG_STATUS, '1);
		expect_reg("status", REG_STATUS, 32'h1040_FF17); // CU0 kept.
		write_reg(3'd0, REG_CAUSE, '1);
		expect_reg("cause", REG_CAUSE, 32'h0000_0300);
		write_reg(3'd0, REG_COMPARE, '1);
		expect_reg("compare", REG_COMPARE, '1);
		write_reg(3'd0, REG_PRID, '1);
		expect_reg("prid", REG_PRID, 32'd0);
		write_reg(3'd0, REG_CAUSE, '0);
		write_reg(3'd0, REG_STATUS, 32'h0000_0010); // UM only.
		expect_reg("status with um", REG_STATUS, 32'h1000_0010);
		if (user_mode !== 1'b1)
			value_error("user_mode", 32'(user_mode), 32'd1);
		if (exc_target !== EBASE_VEC)
			value_error("ebase reset vector", exc_target, EBASE_VEC);
		write_reg(3'd1, REG_PRID, '1); // Ebase.
		#1;
		if (exc_target !== 32'hBFFF_F180)
			value_error("ebase vector", exc_target, 32'hBFFF_F180);
		write_reg(3'd1, REG_PRID, '0);
		#1;
		if (exc_target !== EBASE_VEC)
			value_error("ebase vector restored", exc_target, EBASE_VEC);
		write_reg(3'd0, REG_ENTRY_HI, 32'h1234_5678);
		expect_reg("entry_hi", REG_ENTRY_HI, 32'h1234_4078);
		if (asid !== 8'h78)
			value_error("asid", 32'(asid), 32'h78);
	endtask

	task automatic count_and_random();
		Word_t c0;
		Word_t c1;
		Word_t v;
		int    gap;
		gap = 3 + int'($urandom % 8);
		read_reg(REG_COUNT, c0);
		repeat (gap - 1) @(posedge clk);
		read_reg(REG_COUNT, c1);
		if (c1 !== c0 + gap)
			value_error("count difference", c1 - c0, 32'(gap));
		for (int i = 0; i < 40; i++)
		begin
			read_reg(REG_RANDOM, v);
			if ($isunknown(v) || v == 32'd0 || v >= 32'd16)
				value_error("random outside 1..15", v, 32'd1);
		end
	endtask

	task automatic exception_entry();
		Word_t old_hi;
		write_reg(3'd0, REG_STATUS, 32'h0040_0000); // BEV on.
		#1;
		if (exc_target !== BEV_VEC)
			value_error("bev vector", exc_target, BEV_VEC);
		step();
		adel = 1'b1;
		pc = 32'h0040_0100;
		bad_addr = 32'h0040_0101;
		pulse(1'b1, BEV_VEC);
		expect_reg("epc", REG_EPC, 32'h0040_0100);
		expect_reg("cause adel", REG_CAUSE, cause_word(1'b0, 8'h00, 5'h04));
		expect_reg("bad_vaddr", REG_BAD_VADDR, 32'h0040_0101);
		expect_reg("status exl", REG_STATUS, 32'h1040_0002);
		write_reg(3'd0, REG_STATUS, 32'h0040_0000);
		step();
		adel = 1'b1;
		in_delayslot = 1'b1;
		pc = 32'h0040_0200;
		bad_addr = 32'h0040_0204;
		pulse(1'b1, BEV_VEC);
		expect_reg("epc in delay slot", REG_EPC, 32'h0040_01FC);
		expect_reg("cause bd", REG_CAUSE, cause_word(1'b1, 8'h00, 5'h04));
		step(); // Nested, EXL still set.
		syscall = 1'b1;
		pc = 32'h0040_0300;
		pulse(1'b1, BEV_VEC);
		expect_reg("epc kept", REG_EPC, 32'h0040_01FC);
		expect_reg("cause syscall", REG_CAUSE, cause_word(1'b1, 8'h00, 5'h08));
		write_reg(3'd0, REG_STATUS, 32'h0000_0000);
		#1;
		if (exc_target !== EBASE_VEC)
			value_error("ebase vector", exc_target, EBASE_VEC);
		read_reg(REG_ENTRY_HI, old_hi);
		step();
		tlbl = 1'b1;
		pc = 32'h0040_0400;
		bad_addr = 32'hABCD_E123;
		pulse(1'b1, EBASE_VEC);
		expect_reg("context", REG_CONTEXT, {9'd0, 19'h55E6F, 4'd0});
		expect_reg("entry_hi vpn2", REG_ENTRY_HI, {19'h55E6F, old_hi[12:0]});
		expect_reg("cause tlbl", REG_CAUSE, cause_word(1'b0, 8'h00, 5'h02));
		write_reg(3'd0, REG_STATUS, 32'h0000_0000);
		step();
		adel = 1'b1;
		syscall = 1'b1;
		pulse(1'b1, EBASE_VEC);
		expect_reg("cause priority", REG_CAUSE, cause_word(1'b0, 8'h00, 5'h04));
	endtask

	task automatic interrupt_and_eret();
		write_reg(3'd0, REG_STATUS, 32'h0000_0401); // IE, IM2.
		step();
		ext_int = 6'b000001;
		pc = 32'h0040_0500;
		pulse(1'b1, EBASE_VEC);
		expect_reg("cause int", REG_CAUSE, cause_word(1'b0, 8'h04, 5'h00));
		expect_reg("epc int", REG_EPC, 32'h0040_0500);
		write_reg(3'd0, REG_STATUS, 32'h0000_0400);
		step();
		ext_int = 6'b000001;
		pulse(1'b0, EBASE_VEC);
		expect_reg("status masked int", REG_STATUS, 32'h1000_0400);
		write_reg(3'd0, REG_STATUS, 32'h0000_0402);
		step();
		eret = 1'b1;
		pulse(1'b1, 32'h0040_0500);
		expect_reg("status after eret", REG_STATUS, 32'h1000_0400);
	endtask

	task automatic tlb_results();
		step();
		tlbr_res = '{vpn2: 19'h5A5A5, asid: 8'hC3, G: 1'b1, pfn0: 24'h12_3456,
			pfn1: 24'hAB_CDEF, c0: 3'd3, c1: 3'd5, d0: 1'b1, d1: 1'b0, v0: 1'b1, v1: 1'b1};
		tlbr_req = 1'b1;
		step();
		clear_flags();
		expect_reg("tlbr entry_hi", REG_ENTRY_HI, {19'h5A5A5, 5'd0, 8'hC3});
		expect_reg("tlbr entry_lo0", REG_ENTRY_LO0, {2'b00, 24'h12_3456, 3'd3, 3'b111});
		expect_reg("tlbr entry_lo1", REG_ENTRY_LO1, {2'b00, 24'hAB_CDEF, 3'd5, 3'b011});
		step();
		tlbp_req = 1'b1;
		tlbp_res = 32'h8000_000A;
		step();
		clear_flags();
		expect_reg("tlbp index", REG_INDEX, 32'h8000_000A);
	endtask

	// ****************************************
	initial
	begin
		void'($urandom(32'h32b3b60a));
		errors  = 0;
		clk     = 1'b0;
		rst     = 1'b1;
		raddr   = '0;
		rsel    = 3'd0;
		wr_we   = 1'b0;
		wr_sel  = 3'd0;
		wr_addr = '0;
		wr_data = '0;
		clear_flags();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_values();
		masked_writes();
		count_and_random();
		exception_entry();
		interrupt_and_eret();
		tlb_results();
		step();
		assert_fails = uut.u_cp0.u_asserts.fail_count;
		$display("Summary: %0d errors, %0d assertion failures", errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial
	begin
		#(NUM_TESTS * 200 * CLK_PERIOD);
		$display("Timeout: the tests did not finish in %0d cycles", NUM_TESTS * 200);
		$display("Test FAILED");
		$finish;
	end

endmodule
